// ==== branch_target_gen.sv ====
// branch and jump target
`timescale 1ns/1ns

module branch_target_gen (
    input  mips_decoder_pkg::data_t i_inst,
    input  mips_decoder_pkg::addr_t i_pc,
    input  logic                    i_is_jump,
    output mips_decoder_pkg::addr_t o_target
);
    import mips_decoder_pkg::*;

    addr_t offset;
    addr_t jump_target;

    // word offset, sign extended
    assign offset      = {{14{i_inst[15]}}, i_inst[15:0], 2'b00};
    assign jump_target = {4'b0000, i_inst[25:0], 2'b00};

    assign o_target = i_is_jump ? jump_target : i_pc + addr_t'(4) + offset;

endmodule

// ==== immediate_gen.sv ====
// immediate generation
`timescale 1ns/1ns
`include "mips_decoder_settings.svh"

module immediate_gen (
    input  mips_decoder_pkg::data_t    i_inst,
    input  mips_decoder_pkg::addr_t    i_pc,
    input  mips_decoder_pkg::imm_sel_t i_imm_sel,
    output logic                       o_uses_immediate,
    output mips_decoder_pkg::data_t    o_immediate
);
    import mips_decoder_pkg::*;

    logic [15:0] imm16;
    addr_t       link;

    assign imm16 = i_inst[15:0];
    assign link  = i_pc + addr_t'(8); // return past the delay slot

    always_comb
    begin
        case (i_imm_sel)
            `MIPS_IMM_SIGN:  o_immediate = {{16{imm16[15]}}, imm16};
            `MIPS_IMM_ZERO:  o_immediate = {16'h0000, imm16};
            `MIPS_IMM_SHAMT: o_immediate = {27'd0, i_inst[10:6]};
            `MIPS_IMM_LUI:   o_immediate = {imm16, 16'h0000};
            `MIPS_IMM_LINK:  o_immediate = data_t'(link);
            default:         o_immediate = '0;
        endcase
    end

    assign o_uses_immediate = (i_imm_sel != `MIPS_IMM_NONE);

endmodule

// ==== inst_field_decode.sv ====
// instruction field decode
`timescale 1ns/1ns
`include "mips_decoder_settings.svh"

module inst_field_decode (
    input  mips_decoder_pkg::data_t    i_inst,
    output mips_decoder_pkg::dec_ctl_t o_ctl,
    output logic                       o_supported
);
    import mips_decoder_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;

    assign opcode = i_inst[31:26];
    assign funct  = i_inst[5:0];
    assign rd     = i_inst[15:11];

    function automatic dec_ctl_t alu_op(
        input alu_ctl_t alu,
        input rs_sel_t  rs_sel,
        input logic     uses_rt,
        input rw_sel_t  rw_sel,
        input imm_sel_t imm_sel
    );
        dec_ctl_t c;
        c         = '0;
        c.alu_ctl = alu;
        c.rs_sel  = rs_sel;
        c.uses_rt = uses_rt;
        c.rw_sel  = rw_sel;
        c.imm_sel = imm_sel;
        return c;
    endfunction

    function automatic dec_ctl_t rtype(input alu_ctl_t alu);
        return alu_op(alu, `MIPS_RS_RS, 1'b1, `MIPS_RW_RD, `MIPS_IMM_NONE);
    endfunction

    // sll/srl/sra read rt through the rs slot
    function automatic dec_ctl_t shift(input alu_ctl_t alu);
        return alu_op(alu, `MIPS_RS_RT, 1'b0, `MIPS_RW_RD, `MIPS_IMM_SHAMT);
    endfunction

    function automatic dec_ctl_t itype(input alu_ctl_t alu, input imm_sel_t imm_sel);
        return alu_op(alu, `MIPS_RS_RS, 1'b0, `MIPS_RW_RT, imm_sel);
    endfunction

    function automatic dec_ctl_t branch(input alu_ctl_t alu);
        dec_ctl_t c;
        c                = alu_op(alu, `MIPS_RS_RS, 1'b1, `MIPS_RW_NONE, `MIPS_IMM_NONE);
        c.is_branch_jump = 1'b1;
        return c;
    endfunction

    function automatic dec_ctl_t jump(
        input alu_ctl_t alu,
        input rs_sel_t  rs_sel,
        input rw_sel_t  rw_sel,
        input imm_sel_t imm_sel,
        input logic     is_reg
    );
        dec_ctl_t c;
        c                = alu_op(alu, rs_sel, 1'b0, rw_sel, imm_sel);
        c.is_branch_jump = 1'b1;
        c.is_jump        = 1'b1;
        c.is_jump_reg    = is_reg;
        return c;
    endfunction

    // lw writes rt, sw reads it
    function automatic dec_ctl_t mem(input logic write);
        dec_ctl_t c;
        c = alu_op(`MIPS_ALU_ADD, `MIPS_RS_RS, write,
                   write ? `MIPS_RW_NONE : `MIPS_RW_RT, `MIPS_IMM_SIGN);
        c.is_mem_access = 1'b1;
        c.mem_write     = write;
        return c;
    endfunction

    function automatic dec_ctl_t cop0(input alu_ctl_t alu);
        return alu_op(alu, `MIPS_RS_NONE, 1'b1, `MIPS_RW_NONE, `MIPS_IMM_NONE);
    endfunction

    always_comb
    begin
        o_ctl       = '0;
        o_supported = 1'b1;
        case (opcode)
            `MIPS_OP_RTYPE:
            begin
                case (funct)
                    `MIPS_FN_ADD:  o_ctl = rtype(`MIPS_ALU_ADD);
                    `MIPS_FN_ADDU: o_ctl = rtype(`MIPS_ALU_ADDU);
                    `MIPS_FN_SUB:  o_ctl = rtype(`MIPS_ALU_SUB);
                    `MIPS_FN_SUBU: o_ctl = rtype(`MIPS_ALU_SUBU);
                    `MIPS_FN_AND:  o_ctl = rtype(`MIPS_ALU_AND);
                    `MIPS_FN_OR:   o_ctl = rtype(`MIPS_ALU_OR);
                    `MIPS_FN_XOR:  o_ctl = rtype(`MIPS_ALU_XOR);
                    `MIPS_FN_NOR:  o_ctl = rtype(`MIPS_ALU_NOR);
                    `MIPS_FN_SLL:  o_ctl = shift(`MIPS_ALU_SLL);
                    `MIPS_FN_SRL:  o_ctl = shift(`MIPS_ALU_SRL);
                    `MIPS_FN_SRA:  o_ctl = shift(`MIPS_ALU_SRA);
                    `MIPS_FN_SLLV: o_ctl = rtype(`MIPS_ALU_SLLV);
                    `MIPS_FN_SRLV: o_ctl = rtype(`MIPS_ALU_SRLV);
                    `MIPS_FN_SRAV: o_ctl = rtype(`MIPS_ALU_SRAV);
                    `MIPS_FN_SLT:  o_ctl = rtype(`MIPS_ALU_SLT);
                    `MIPS_FN_SLTU: o_ctl = rtype(`MIPS_ALU_SLTU);
                    `MIPS_FN_JR:
                        o_ctl = jump(`MIPS_ALU_NOP, `MIPS_RS_RS, `MIPS_RW_NONE,
                                     `MIPS_IMM_NONE, 1'b1);
                    `MIPS_FN_JALR:
                        o_ctl = jump(`MIPS_ALU_OR, `MIPS_RS_RS, `MIPS_RW_RA,
                                     `MIPS_IMM_LINK, 1'b1);
                    default:       o_supported = 1'b0; // mul/div land here too
                endcase
            end
            `MIPS_OP_ADDI:   o_ctl = itype(`MIPS_ALU_ADD, `MIPS_IMM_SIGN);
            `MIPS_OP_ADDIU:  o_ctl = itype(`MIPS_ALU_ADDU, `MIPS_IMM_SIGN);
            `MIPS_OP_SLTI:   o_ctl = itype(`MIPS_ALU_SLT, `MIPS_IMM_SIGN);
            `MIPS_OP_SLTIU:  o_ctl = itype(`MIPS_ALU_SLTU, `MIPS_IMM_SIGN);
            `MIPS_OP_ANDI:   o_ctl = itype(`MIPS_ALU_AND, `MIPS_IMM_ZERO);
            `MIPS_OP_ORI:    o_ctl = itype(`MIPS_ALU_OR, `MIPS_IMM_ZERO);
            `MIPS_OP_XORI:   o_ctl = itype(`MIPS_ALU_XOR, `MIPS_IMM_ZERO);
            `MIPS_OP_LUI:    // 0 | imm, so no rs
                o_ctl = alu_op(`MIPS_ALU_OR, `MIPS_RS_NONE, 1'b0, `MIPS_RW_RT, `MIPS_IMM_LUI);
            `MIPS_OP_BEQ:    o_ctl = branch(`MIPS_ALU_BEQ);
            `MIPS_OP_BNE:    o_ctl = branch(`MIPS_ALU_BNE);
            `MIPS_OP_BLEZ:   o_ctl = branch(`MIPS_ALU_BLEZ);
            `MIPS_OP_BGTZ:   o_ctl = branch(`MIPS_ALU_BGTZ);
            `MIPS_OP_REGIMM: o_ctl = branch(i_inst[16] ? `MIPS_ALU_BGEZ : `MIPS_ALU_BLTZ);
            `MIPS_OP_J:
                o_ctl = jump(`MIPS_ALU_NOP, `MIPS_RS_NONE, `MIPS_RW_NONE, `MIPS_IMM_NONE, 1'b0);
            `MIPS_OP_JAL:
                o_ctl = jump(`MIPS_ALU_OR, `MIPS_RS_NONE, `MIPS_RW_RA, `MIPS_IMM_LINK, 1'b0);
            `MIPS_OP_LW:     o_ctl = mem(1'b0);
            `MIPS_OP_SW:     o_ctl = mem(1'b1);
            `MIPS_OP_COP0:
            begin
                case (rd)
                    `MIPS_MTC0_PASS: o_ctl = cop0(`MIPS_ALU_MTC0_PASS);
                    `MIPS_MTC0_FAIL: o_ctl = cop0(`MIPS_ALU_MTC0_FAIL);
                    `MIPS_MTC0_DONE: o_ctl = cop0(`MIPS_ALU_MTC0_DONE);
                    default:         o_supported = 1'b0;
                endcase
            end
            default:         o_supported = 1'b0; // byte/half mem ops and unknowns
        endcase
    end

    // an unsupported encoding must leave the nop selectors
    always_comb
    begin
        assert final (o_supported || (o_ctl.rs_sel == `MIPS_RS_NONE
                      && o_ctl.rw_sel == `MIPS_RW_NONE && o_ctl.imm_sel == `MIPS_IMM_NONE))
        else $error("selectors set on unsupported encoding %h", i_inst);
    end

endmodule

// ==== mips_decoder.sv ====
// mips decode stage
`timescale 1ns/1ns

module mips_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_inst_valid,
    input  mips_decoder_pkg::data_t    i_inst,
    input  mips_decoder_pkg::addr_t    i_pc,
    output logic                       o_valid,
    output logic                       o_illegal,
    output mips_decoder_pkg::dec_out_t o_dec
);
    import mips_decoder_pkg::*;

    dec_ctl_t ctl;
    logic     supported;
    addr_t    target;
    dec_out_t dec;
    logic     accept;

    inst_field_decode i_inst_field_decode (
        .i_inst      (i_inst),
        .o_ctl       (ctl),
        .o_supported (supported)
    );

    operand_select i_operand_select (
        .i_inst    (i_inst),
        .i_rs_sel  (ctl.rs_sel),
        .i_uses_rt (ctl.uses_rt),
        .i_rw_sel  (ctl.rw_sel),
        .o_uses_rs (dec.uses_rs),
        .o_rs_addr (dec.rs_addr),
        .o_uses_rt (dec.uses_rt),
        .o_rt_addr (dec.rt_addr),
        .o_uses_rw (dec.uses_rw),
        .o_rw_addr (dec.rw_addr)
    );

    immediate_gen i_immediate_gen (
        .i_inst           (i_inst),
        .i_pc             (i_pc),
        .i_imm_sel        (ctl.imm_sel),
        .o_uses_immediate (dec.uses_immediate),
        .o_immediate      (dec.immediate)
    );

    branch_target_gen i_branch_target_gen (
        .i_inst    (i_inst),
        .i_pc      (i_pc),
        .i_is_jump (ctl.is_jump),
        .o_target  (target)
    );

    assign dec.alu_ctl        = ctl.alu_ctl;
    assign dec.is_branch_jump = ctl.is_branch_jump;
    assign dec.is_jump        = ctl.is_jump;
    assign dec.is_jump_reg    = ctl.is_jump_reg;
    assign dec.is_mem_access  = ctl.is_mem_access;
    assign dec.mem_write      = ctl.mem_write;
    // jr/jalr resolve their target from rs later
    assign dec.branch_target  = (ctl.is_branch_jump && !ctl.is_jump_reg) ? target : '0;

    assign accept = i_inst_valid && supported;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
            o_dec     <= '0;
        end
        else
        begin
            o_valid   <= accept;
            o_illegal <= i_inst_valid && !supported; // one pulse per bad word
            o_dec     <= accept ? dec : '0; // nop bundle otherwise
        end
    end

    a_valid_illegal_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_valid && o_illegal));

endmodule

// ==== mips_decoder_pkg.sv ====
// mips decoder types
`include "mips_decoder_settings.svh"

package mips_decoder_pkg;

    typedef logic [`MIPS_DATA_WIDTH-1:0]     data_t;
    typedef logic [`MIPS_ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [4:0]                      alu_ctl_t;
    typedef logic [2:0]                      imm_sel_t;
    typedef logic [1:0]                      rs_sel_t;
    typedef logic [1:0]                      rw_sel_t;

    // raw result of the opcode / funct case
    typedef struct packed {
        alu_ctl_t alu_ctl;
        logic     is_branch_jump;
        logic     is_jump;
        logic     is_jump_reg;
        logic     is_mem_access;
        logic     mem_write;
        logic     uses_rt;
        rs_sel_t  rs_sel;
        rw_sel_t  rw_sel;
        imm_sel_t imm_sel;
    } dec_ctl_t;

    typedef struct packed {
        alu_ctl_t  alu_ctl;
        logic      is_branch_jump;
        logic      is_jump;
        logic      is_jump_reg;
        addr_t     branch_target;
        logic      is_mem_access;
        logic      mem_write;
        logic      uses_rs;
        reg_addr_t rs_addr;
        logic      uses_rt;
        reg_addr_t rt_addr;
        logic      uses_immediate;
        data_t     immediate;
        logic      uses_rw;
        reg_addr_t rw_addr;
    } dec_out_t;

endpackage

// ==== mips_decoder_settings.svh ====
// mips decoder settings
`ifndef MIPS_DECODER_SETTINGS_SVH
`define MIPS_DECODER_SETTINGS_SVH

`define MIPS_DATA_WIDTH     32
`define MIPS_ADDR_WIDTH     32
`define MIPS_REG_ADDR_WIDTH 5
`define MIPS_REG_RA         5'd31

`define MIPS_OP_RTYPE  6'h00
`define MIPS_OP_REGIMM 6'h01 // bgez / bltz
`define MIPS_OP_J      6'h02
`define MIPS_OP_JAL    6'h03
`define MIPS_OP_BEQ    6'h04
`define MIPS_OP_BNE    6'h05
`define MIPS_OP_BLEZ   6'h06
`define MIPS_OP_BGTZ   6'h07
`define MIPS_OP_ADDI   6'h08
`define MIPS_OP_ADDIU  6'h09
`define MIPS_OP_SLTI   6'h0a
`define MIPS_OP_SLTIU  6'h0b
`define MIPS_OP_ANDI   6'h0c
`define MIPS_OP_ORI    6'h0d
`define MIPS_OP_XORI   6'h0e
`define MIPS_OP_LUI    6'h0f
`define MIPS_OP_COP0   6'h10
`define MIPS_OP_LW     6'h23
`define MIPS_OP_SW     6'h2b

`define MIPS_FN_SLL  6'h00
`define MIPS_FN_SRL  6'h02
`define MIPS_FN_SRA  6'h03
`define MIPS_FN_SLLV 6'h04
`define MIPS_FN_SRLV 6'h06
`define MIPS_FN_SRAV 6'h07
`define MIPS_FN_JR   6'h08
`define MIPS_FN_JALR 6'h09
`define MIPS_FN_ADD  6'h20
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUB  6'h22
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND  6'h24
`define MIPS_FN_OR   6'h25
`define MIPS_FN_XOR  6'h26
`define MIPS_FN_NOR  6'h27
`define MIPS_FN_SLT  6'h2a
`define MIPS_FN_SLTU 6'h2b

`define MIPS_MTC0_PASS 5'd23
`define MIPS_MTC0_FAIL 5'd24
`define MIPS_MTC0_DONE 5'd25

`define MIPS_ALU_NOP       5'd0
`define MIPS_ALU_ADD       5'd1
`define MIPS_ALU_ADDU      5'd2
`define MIPS_ALU_SUB       5'd3
`define MIPS_ALU_SUBU      5'd4
`define MIPS_ALU_AND       5'd5
`define MIPS_ALU_OR        5'd6
`define MIPS_ALU_XOR       5'd7
`define MIPS_ALU_NOR       5'd8
`define MIPS_ALU_SLL       5'd9
`define MIPS_ALU_SRL       5'd10
`define MIPS_ALU_SRA       5'd11
`define MIPS_ALU_SLLV      5'd12
`define MIPS_ALU_SRLV      5'd13
`define MIPS_ALU_SRAV      5'd14
`define MIPS_ALU_SLT       5'd15
`define MIPS_ALU_SLTU      5'd16
`define MIPS_ALU_BEQ       5'd17
`define MIPS_ALU_BNE       5'd18
`define MIPS_ALU_BLEZ      5'd19
`define MIPS_ALU_BGEZ      5'd20
`define MIPS_ALU_BLTZ      5'd21
`define MIPS_ALU_BGTZ      5'd22
`define MIPS_ALU_MTC0_PASS 5'd23
`define MIPS_ALU_MTC0_FAIL 5'd24
`define MIPS_ALU_MTC0_DONE 5'd25

`define MIPS_IMM_NONE  3'd0
`define MIPS_IMM_SIGN  3'd1
`define MIPS_IMM_ZERO  3'd2
`define MIPS_IMM_SHAMT 3'd3
`define MIPS_IMM_LUI   3'd4
`define MIPS_IMM_LINK  3'd5 // pc + 8

`define MIPS_RS_NONE 2'd0
`define MIPS_RS_RS   2'd1
`define MIPS_RS_RT   2'd2

`define MIPS_RW_NONE 2'd0
`define MIPS_RW_RD   2'd1
`define MIPS_RW_RT   2'd2
`define MIPS_RW_RA   2'd3

`endif

// ==== operand_select.sv ====
// register operand select
`timescale 1ns/1ns
`include "mips_decoder_settings.svh"

module operand_select (
    input  mips_decoder_pkg::data_t     i_inst,
    input  mips_decoder_pkg::rs_sel_t   i_rs_sel,
    input  logic                        i_uses_rt,
    input  mips_decoder_pkg::rw_sel_t   i_rw_sel,
    output logic                        o_uses_rs,
    output mips_decoder_pkg::reg_addr_t o_rs_addr,
    output logic                        o_uses_rt,
    output mips_decoder_pkg::reg_addr_t o_rt_addr,
    output logic                        o_uses_rw,
    output mips_decoder_pkg::reg_addr_t o_rw_addr
);
    import mips_decoder_pkg::*;

    reg_addr_t rs_field;
    reg_addr_t rt_field;
    reg_addr_t rd_field;

    assign rs_field = i_inst[25:21];
    assign rt_field = i_inst[20:16];
    assign rd_field = i_inst[15:11];

    always_comb
    begin
        case (i_rs_sel)
            `MIPS_RS_RS: o_rs_addr = rs_field;
            `MIPS_RS_RT: o_rs_addr = rt_field; // shifts by shamt
            default:     o_rs_addr = '0;
        endcase
        case (i_rw_sel)
            `MIPS_RW_RD: o_rw_addr = rd_field;
            `MIPS_RW_RT: o_rw_addr = rt_field;
            `MIPS_RW_RA: o_rw_addr = `MIPS_REG_RA; // jal/jalr link
            default:     o_rw_addr = '0;
        endcase
    end

    assign o_rt_addr = i_uses_rt ? rt_field : '0;

    // register zero never counts as a dependency
    assign o_uses_rs = |o_rs_addr;
    assign o_uses_rt = |o_rt_addr;
    assign o_uses_rw = |o_rw_addr;

    always_comb
    begin
        assert final (!(o_uses_rs && o_rs_addr == '0) && !(o_uses_rt && o_rt_addr == '0)
                      && !(o_uses_rw && o_rw_addr == '0))
        else $error("uses flag raised for register zero");
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the decoder testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert --timing -f src.f --top-module tb_mips_decoder -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q '\*\*\* PASSED \*\*\*' sim.log && exit 0 || exit 1

// ==== src.f ====
+incdir+.
mips_decoder_pkg.sv
inst_field_decode.sv
operand_select.sv
immediate_gen.sv
branch_target_gen.sv
mips_decoder.sv
tb_mips_decoder.sv

// ==== tb_mips_decoder.sv ====
// mips decoder testbench
`timescale 1ns/1ns
`include "mips_decoder_settings.svh"

module tb_mips_decoder;
    import mips_decoder_pkg::*;

    typedef struct packed {
        logic     valid;
        logic     illegal;
        dec_out_t dec;
    } expect_t;

    localparam int ROUNDS    = 4;
    // words per round in tests 2 to 6, plus idles and the fixed cases
    localparam int NUM_ISSUE = ROUNDS * (18 + 8 + 10 + 5 + 9) + 7 + 60;

    logic     clk;
    logic     rst_n;
    logic     i_inst_valid;
    data_t    i_inst;
    addr_t    i_pc;
    logic     o_valid;
    logic     o_illegal;
    dec_out_t o_dec;
    expect_t  exp_r;
    logic     started;
    int       errors;
    int       tests;
    int       test_base;
    logic [31:0] lcg_state;

    logic [5:0] rtype_fn [16] = '{`MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB, `MIPS_FN_SUBU,
        `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_NOR, `MIPS_FN_SLL, `MIPS_FN_SRL,
        `MIPS_FN_SRA, `MIPS_FN_SLLV, `MIPS_FN_SRLV, `MIPS_FN_SRAV, `MIPS_FN_SLT, `MIPS_FN_SLTU};
    logic [5:0] itype_op [8] = '{`MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU,
        `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI};

    mips_decoder i_mips_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .o_valid      (o_valid),
        .o_illegal    (o_illegal),
        .o_dec        (o_dec)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ALU code from the opcode, or from funct for R-type; nop when unknown
    function automatic alu_ctl_t alu_for(logic [5:0] op, logic [5:0] fn, logic b16);
        case (op)
            `MIPS_OP_RTYPE:
                case (fn)
                    `MIPS_FN_ADD:  return `MIPS_ALU_ADD;
                    `MIPS_FN_ADDU: return `MIPS_ALU_ADDU;
                    `MIPS_FN_SUB:  return `MIPS_ALU_SUB;
                    `MIPS_FN_SUBU: return `MIPS_ALU_SUBU;
                    `MIPS_FN_AND:  return `MIPS_ALU_AND;
                    `MIPS_FN_OR:   return `MIPS_ALU_OR;
                    `MIPS_FN_XOR:  return `MIPS_ALU_XOR;
                    `MIPS_FN_NOR:  return `MIPS_ALU_NOR;
                    `MIPS_FN_SLL:  return `MIPS_ALU_SLL;
                    `MIPS_FN_SRL:  return `MIPS_ALU_SRL;
                    `MIPS_FN_SRA:  return `MIPS_ALU_SRA;
                    `MIPS_FN_SLLV: return `MIPS_ALU_SLLV;
                    `MIPS_FN_SRLV: return `MIPS_ALU_SRLV;
                    `MIPS_FN_SRAV: return `MIPS_ALU_SRAV;
                    `MIPS_FN_SLT:  return `MIPS_ALU_SLT;
                    `MIPS_FN_SLTU: return `MIPS_ALU_SLTU;
                    default:       return `MIPS_ALU_NOP;
                endcase
            `MIPS_OP_ADDI, `MIPS_OP_LW, `MIPS_OP_SW: return `MIPS_ALU_ADD;
            `MIPS_OP_ADDIU:  return `MIPS_ALU_ADDU;
            `MIPS_OP_SLTI:   return `MIPS_ALU_SLT;
            `MIPS_OP_SLTIU:  return `MIPS_ALU_SLTU;
            `MIPS_OP_ANDI:   return `MIPS_ALU_AND;
            `MIPS_OP_ORI, `MIPS_OP_LUI, `MIPS_OP_JAL: return `MIPS_ALU_OR;
            `MIPS_OP_XORI:   return `MIPS_ALU_XOR;
            `MIPS_OP_BEQ:    return `MIPS_ALU_BEQ;
            `MIPS_OP_BNE:    return `MIPS_ALU_BNE;
            `MIPS_OP_BLEZ:   return `MIPS_ALU_BLEZ;
            `MIPS_OP_BGTZ:   return `MIPS_ALU_BGTZ;
            `MIPS_OP_REGIMM: return b16 ? `MIPS_ALU_BGEZ : `MIPS_ALU_BLTZ;
            default:         return `MIPS_ALU_NOP;
        endcase
    endfunction

    function automatic expect_t model(logic v, data_t inst, addr_t pc);
        expect_t     e;
        dec_out_t    d;
        logic        sup;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [15:0] imm;
        data_t       sext;
        d    = '0;
        sup  = 1'b1;
        op   = inst[31:26];
        fn   = inst[5:0];
        imm  = inst[15:0];
        sext = {{16{imm[15]}}, imm};
        d.alu_ctl = alu_for(op, fn, inst[16]);
        case (op)
            `MIPS_OP_RTYPE:
                if (fn == `MIPS_FN_JR || fn == `MIPS_FN_JALR)
                begin
                    d.is_branch_jump = 1'b1;
                    d.is_jump        = 1'b1;
                    d.is_jump_reg    = 1'b1;
                    d.rs_addr        = inst[25:21];
                    if (fn == `MIPS_FN_JALR)
                    begin
                        d.alu_ctl        = `MIPS_ALU_OR;
                        d.rw_addr        = 5'd31;
                        d.uses_immediate = 1'b1;
                        d.immediate      = pc + 32'd8;
                    end
                end
                else if (fn == `MIPS_FN_SLL || fn == `MIPS_FN_SRL || fn == `MIPS_FN_SRA)
                begin
                    d.rs_addr        = inst[20:16]; // rt into the rs slot
                    d.rw_addr        = inst[15:11];
                    d.uses_immediate = 1'b1;
                    d.immediate      = {27'd0, inst[10:6]};
                end
                else if (d.alu_ctl == `MIPS_ALU_NOP)
                    sup = 1'b0;
                else
                begin
                    d.rs_addr = inst[25:21];
                    d.rt_addr = inst[20:16];
                    d.rw_addr = inst[15:11];
                end
            `MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU,
            `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI, `MIPS_OP_LW:
            begin
                d.rs_addr        = (op == `MIPS_OP_LUI) ? 5'd0 : inst[25:21];
                d.rw_addr        = inst[20:16];
                d.uses_immediate = 1'b1;
                d.is_mem_access  = (op == `MIPS_OP_LW);
                if (op == `MIPS_OP_LUI)
                    d.immediate = {imm, 16'h0000};
                else if (op == `MIPS_OP_ANDI || op == `MIPS_OP_ORI || op == `MIPS_OP_XORI)
                    d.immediate = {16'h0000, imm};
                else
                    d.immediate = sext;
            end
            `MIPS_OP_SW:
            begin
                d.rs_addr        = inst[25:21];
                d.rt_addr        = inst[20:16];
                d.uses_immediate = 1'b1;
                d.immediate      = sext;
                d.is_mem_access  = 1'b1;
                d.mem_write      = 1'b1;
            end
            `MIPS_OP_BEQ, `MIPS_OP_BNE, `MIPS_OP_BLEZ, `MIPS_OP_BGTZ, `MIPS_OP_REGIMM:
            begin
                d.is_branch_jump = 1'b1;
                d.rs_addr        = inst[25:21];
                d.rt_addr        = inst[20:16];
                d.branch_target  = pc + 32'd4 + (sext << 2);
            end
            `MIPS_OP_J, `MIPS_OP_JAL:
            begin
                d.is_branch_jump = 1'b1;
                d.is_jump        = 1'b1;
                d.branch_target  = {4'b0000, inst[25:0], 2'b00};
                if (op == `MIPS_OP_JAL)
                begin
                    d.rw_addr        = 5'd31;
                    d.uses_immediate = 1'b1;
                    d.immediate      = pc + 32'd8;
                end
            end
            `MIPS_OP_COP0:
                case (inst[15:11])
                    5'd23:   d.alu_ctl = `MIPS_ALU_MTC0_PASS;
                    5'd24:   d.alu_ctl = `MIPS_ALU_MTC0_FAIL;
                    5'd25:   d.alu_ctl = `MIPS_ALU_MTC0_DONE;
                    default: sup = 1'b0;
                endcase
            default: sup = 1'b0;
        endcase
        if (op == `MIPS_OP_COP0)
            d.rt_addr = inst[20:16];
        d.uses_rs = |d.rs_addr;
        d.uses_rt = |d.rt_addr;
        d.uses_rw = |d.rw_addr;
        e.valid   = v && sup;
        e.illegal = v && !sup;
        e.dec     = (v && sup) ? d : '0;
        return e;
    endfunction

    // expected result, registered like the DUT output
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            exp_r <= '0;
        else
            exp_r <= model(i_inst_valid, i_inst, i_pc);
    end

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] want);
        errors++;
        $display("error t=%0t %s got %h expected %h", $time, name, got, want);
    endtask

    a_valid: assert property (@(posedge clk) disable iff (!started) o_valid == exp_r.valid)
        else mismatch("o_valid", $sampled(o_valid), $sampled(exp_r.valid));
    a_illegal: assert property (@(posedge clk) disable iff (!started)
        o_illegal == exp_r.illegal)
        else mismatch("o_illegal", $sampled(o_illegal), $sampled(exp_r.illegal));
    a_alu: assert property (@(posedge clk) disable iff (!started)
        o_dec.alu_ctl == exp_r.dec.alu_ctl)
        else mismatch("o_dec.alu_ctl", $sampled(o_dec.alu_ctl), $sampled(exp_r.dec.alu_ctl));
    a_flags: assert property (@(posedge clk) disable iff (!started)
        {o_dec.is_branch_jump, o_dec.is_jump, o_dec.is_jump_reg, o_dec.is_mem_access,
         o_dec.mem_write} == {exp_r.dec.is_branch_jump, exp_r.dec.is_jump,
         exp_r.dec.is_jump_reg, exp_r.dec.is_mem_access, exp_r.dec.mem_write})
        else mismatch("o_dec class flags", $sampled({o_dec.is_branch_jump, o_dec.is_jump,
            o_dec.is_jump_reg, o_dec.is_mem_access, o_dec.mem_write}),
            $sampled({exp_r.dec.is_branch_jump, exp_r.dec.is_jump, exp_r.dec.is_jump_reg,
            exp_r.dec.is_mem_access, exp_r.dec.mem_write}));
    a_target: assert property (@(posedge clk) disable iff (!started)
        o_dec.branch_target == exp_r.dec.branch_target)
        else mismatch("o_dec.branch_target", $sampled(o_dec.branch_target),
            $sampled(exp_r.dec.branch_target));
    a_rs: assert property (@(posedge clk) disable iff (!started)
        {o_dec.uses_rs, o_dec.rs_addr} == {exp_r.dec.uses_rs, exp_r.dec.rs_addr})
        else mismatch("o_dec.rs", $sampled({o_dec.uses_rs, o_dec.rs_addr}),
            $sampled({exp_r.dec.uses_rs, exp_r.dec.rs_addr}));
    a_rt: assert property (@(posedge clk) disable iff (!started)
        {o_dec.uses_rt, o_dec.rt_addr} == {exp_r.dec.uses_rt, exp_r.dec.rt_addr})
        else mismatch("o_dec.rt", $sampled({o_dec.uses_rt, o_dec.rt_addr}),
            $sampled({exp_r.dec.uses_rt, exp_r.dec.rt_addr}));
    a_rw: assert property (@(posedge clk) disable iff (!started)
        {o_dec.uses_rw, o_dec.rw_addr} == {exp_r.dec.uses_rw, exp_r.dec.rw_addr})
        else mismatch("o_dec.rw", $sampled({o_dec.uses_rw, o_dec.rw_addr}),
            $sampled({exp_r.dec.uses_rw, exp_r.dec.rw_addr}));
    a_uses_imm: assert property (@(posedge clk) disable iff (!started)
        o_dec.uses_immediate == exp_r.dec.uses_immediate)
        else mismatch("o_dec.uses_immediate", $sampled(o_dec.uses_immediate),
            $sampled(exp_r.dec.uses_immediate));
    a_imm: assert property (@(posedge clk) disable iff (!started)
        o_dec.immediate == exp_r.dec.immediate)
        else mismatch("o_dec.immediate", $sampled(o_dec.immediate),
            $sampled(exp_r.dec.immediate));

    task automatic issue(data_t inst);
        @(posedge clk);
        #2;
        i_inst_valid = 1'b1;
        i_inst       = inst;
        i_pc         = lcg() & 32'hffff_fffc;
    endtask

    task automatic idle();
        @(posedge clk);
        #2;
        i_inst_valid = 1'b0;
        i_inst       = lcg();
    endtask

    // random fields, all zero in the first round
    function automatic data_t word(logic [5:0] op, logic [5:0] fn, int round);
        data_t w;
        w = (round == 0) ? 32'd0 : lcg();
        return {op, w[25:6], fn};
    endfunction

    task automatic end_test(string name);
        idle();
        idle();
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    initial
    begin
        started      = 1'b0;
        errors       = 0;
        tests        = 0;
        test_base    = 0;
        lcg_state    = 32'd40;
        rst_n        = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        #1 started = 1'b1;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (3) idle();
        end_test("reset and nop bundle");

        for (int r = 0; r < ROUNDS; r++)
        begin
            foreach (rtype_fn[k])
                issue(word(`MIPS_OP_RTYPE, rtype_fn[k], r));
            issue(word(`MIPS_OP_RTYPE, `MIPS_FN_SLL, r) | 32'h03e0_0000);
            issue(word(`MIPS_OP_RTYPE, `MIPS_FN_SRA, r) & 32'hfc1f_ffff);
        end
        end_test("r-type alu and operands");

        for (int r = 0; r < ROUNDS; r++)
            foreach (itype_op[k])
                issue(word(itype_op[k], 6'd0, r) ^ {16'd0, (r[0] ? 16'h8000 : 16'h0000)});
        end_test("i-type immediates");

        for (int r = 0; r < ROUNDS; r++)
        begin
            issue(word(`MIPS_OP_BEQ, 6'd0, r));
            issue(word(`MIPS_OP_BNE, 6'd0, r) | 32'h0000_8000);
            issue(word(`MIPS_OP_BLEZ, 6'd0, r));
            issue(word(`MIPS_OP_BGTZ, 6'd0, r));
            issue((word(`MIPS_OP_REGIMM, 6'd0, r) & 32'hffe0_ffff) | 32'h0001_0000);
            issue(word(`MIPS_OP_REGIMM, 6'd0, r) & 32'hffe0_ffff);
            issue(word(`MIPS_OP_J, 6'd0, r));
            issue(word(`MIPS_OP_JAL, 6'd0, r));
            issue(word(`MIPS_OP_RTYPE, `MIPS_FN_JR, r));
            issue(word(`MIPS_OP_RTYPE, `MIPS_FN_JALR, r));
        end
        end_test("branches and jumps");

        for (int r = 0; r < ROUNDS; r++)
        begin
            issue(word(`MIPS_OP_LW, 6'd0, r));
            issue(word(`MIPS_OP_SW, 6'd0, r) | 32'h0000_8000);
            issue({`MIPS_OP_COP0, 5'd4, 5'(lcg()), 5'd23, 11'd0});
            issue({`MIPS_OP_COP0, 5'd4, 5'(lcg()), 5'd24, 11'd0});
            issue({`MIPS_OP_COP0, 5'd4, 5'(lcg()), 5'd25, 11'd0});
        end
        end_test("memory and mtc0");

        issue({6'h1c, 20'(lcg()), 6'h02}); // mul
        issue({`MIPS_OP_RTYPE, 20'(lcg()), 6'h1a}); // div
        issue({6'h20, 26'(lcg())}); // lb
        issue({6'h29, 26'(lcg())}); // sh
        issue({`MIPS_OP_RTYPE, 20'(lcg()), 6'h3f});
        issue({6'h3e, 26'(lcg())});
        issue({`MIPS_OP_COP0, 5'd4, 5'(lcg()), 5'd5, 11'd0});
        for (int r = 0; r < ROUNDS * 3; r++)
        begin
            issue(word(`MIPS_OP_ADDIU, 6'd0, r + 1));
            issue({6'h3e, 26'(lcg())});
            idle();
        end
        end_test("unsupported and back-to-back");

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #(NUM_ISSUE * 20 + 1000);
        $display("timeout: the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
